// File: rtl/tnn_consts.svh
`ifndef TNN_CONSTS_SVH
`define TNN_CONSTS_SVH

// ############################################################
// network dimensions
// ############################################################

`define TNN_FEAT_CNT    8   // input features
`define TNN_FEAT_BITS   4   // unsigned feature width
`define TNN_HIDDEN_CNT  6   // hidden neurons
`define TNN_CLASS_CNT   4   // output classes
`define TNN_SCORE_BITS  4   // signed score, holds +/-6

// ############################################################
// first layer weights, bit h*8+f
// ############################################################

// row nonzero counts are 3, 5, 2, 4, 5, 1
`define TNN_L1_MASK 48'h8079_A648_D325
// 1 = +1, 0 = -1, only read under the mask
`define TNN_L1_SIGN 48'h0031_8440_5205

// ############################################################
// second layer weights, bit c*6+h
// ############################################################

`define TNN_L2_MASK 24'h9E_B7B5   // nonzero entries
`define TNN_L2_SIGN 24'hC0_94A4   // 1 = +1, 0 = -1

`endif

// File: rtl/tnn_feat_pkg.sv
`include "tnn_consts.svh"

// ############################################################
// input side types
// ############################################################

package tnn_feat_pkg;

  // one inference worth of features, feature f at [f]
  typedef logic [`TNN_FEAT_CNT-1:0][`TNN_FEAT_BITS-1:0] feat_vec_t;

  // a feature with its weight sign applied
  // one extra bit so that -15 fits
  typedef logic signed [`TNN_FEAT_BITS:0] feat_sample_t;

endpackage

// File: rtl/tnn_layer_pkg.sv
`include "tnn_consts.svh"

// ############################################################
// layer output types
// ############################################################

package tnn_layer_pkg;

  typedef logic [`TNN_HIDDEN_CNT-1:0] hidden_vec_t;  // 1 = sum >= 0

  // ternary product term, +1 / 0 / -1
  typedef logic signed [1:0] unit_sample_t;

  typedef logic signed [`TNN_SCORE_BITS-1:0] score_t;  // per-class total

  typedef logic [$clog2(`TNN_CLASS_CNT)-1:0] class_idx_t;

  // what the classifier reports once finished
  typedef struct packed {
    logic        valid;      // stays high until reset
    class_idx_t  class_idx;  // winning class
    hidden_vec_t hidden;     // first layer activations
  } tnn_result_t;

endpackage

// File: rtl/tnn_accumulator.sv
`timescale 1ns/1ps

// ############################################################
// signed running sum of one sample per cycle
// ############################################################

module tnn_accumulator #(
  parameter int  SIZE     = 4,                   // samples to be summed
  parameter type sample_t = logic signed [4:0],
  parameter int  ACC_BITS = $bits(sample_t) + $clog2(SIZE + 1)
) (
  input  logic                       clk,
  input  logic                       rst,
  input  sample_t                    sample,
  input  logic                       halt,   // hold the sum
  output logic signed [ACC_BITS-1:0] sum,
  output logic                       sign    // 1 when sum >= 0
);

  logic signed [ACC_BITS-1:0] sample_ext;

  assign sample_ext = ACC_BITS'(sample);  // sign extend

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum <= '0;
    end else if (!halt) begin
      sum <= sum + sample_ext;
    end
  end

  assign sign = ~sum[ACC_BITS-1];

endmodule

// File: rtl/tnn_first_layer.sv
`timescale 1ns/1ps

// ############################################################
// sparse ternary first layer, one nonzero weight per cycle
// ############################################################

module tnn_first_layer #(
  parameter int                             FEAT_CNT   = 8,
  parameter int                             FEAT_BITS  = 4,
  parameter int                             HIDDEN_CNT = 6,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0] MASK       = '0,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0] SIGN       = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  tnn_feat_pkg::feat_vec_t   features,
  output tnn_layer_pkg::hidden_vec_t hidden,
  output logic                      hidden_done
);

  import tnn_feat_pkg::*;

  // nonzero weights in row h
  function automatic int row_nnz(int h);
    int n;
    n = 0;
    for (int f = 0; f < FEAT_CNT; f++) begin
      if (MASK[h*FEAT_CNT+f]) n++;
    end
    return n;
  endfunction

  // feature index of the k-th nonzero weight in row h
  function automatic int feat_of(int h, int k);
    int seen;
    int pos;
    seen = 0;
    pos  = 0;
    for (int f = 0; f < FEAT_CNT; f++) begin
      if (MASK[h*FEAT_CNT+f]) begin
        if (seen == k) pos = f;
        seen++;
      end
    end
    return pos;
  endfunction

  function automatic int max_len();
    int mx;
    mx = 0;
    for (int h = 0; h < HIDDEN_CNT; h++) begin
      if (row_nnz(h) > mx) mx = row_nnz(h);
    end
    return mx;
  endfunction

  localparam int MAX_LEN  = max_len();
  localparam int CNT_BITS = $clog2(MAX_LEN + 1);

  logic [CNT_BITS-1:0] cnt;  // shared sparse index

  assign hidden_done = (cnt == CNT_BITS'(MAX_LEN));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (!hidden_done) begin
      cnt <= cnt + 1'b1;
    end
  end

  for (genvar h = 0; h < HIDDEN_CNT; h++) begin : g_neuron
    localparam int ROW_LEN = row_nnz(h);

    // sparse sample list, padded with zeros so cnt never runs past it
    feat_sample_t samples [MAX_LEN+1];

    for (genvar k = 0; k <= MAX_LEN; k++) begin : g_slot
      if (k < ROW_LEN) begin : g_used
        localparam int F = feat_of(h, k);
        assign samples[k] = SIGN[h*FEAT_CNT+F] ? feat_sample_t'(features[F])
                                               : -feat_sample_t'(features[F]);
      end else begin : g_pad
        assign samples[k] = '0;
      end
    end

    tnn_accumulator #(
      .SIZE     (ROW_LEN),
      .sample_t (feat_sample_t)
    ) u_acc (
      .clk    (clk),
      .rst    (rst),
      .sample (samples[cnt]),
      .halt   (cnt >= CNT_BITS'(ROW_LEN)),  // row used up
      .sum    (),
      .sign   (hidden[h])
    );
  end

endmodule

// File: rtl/tnn_second_layer.sv
`timescale 1ns/1ps

// ############################################################
// dense ternary second layer, one hidden neuron per cycle
// ############################################################

module tnn_second_layer #(
  parameter int                              HIDDEN_CNT = 6,
  parameter int                              CLASS_CNT  = 4,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] MASK       = '0,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] SIGN       = '0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  tnn_layer_pkg::hidden_vec_t hidden,
  input  logic                       hidden_done,  // first layer finished
  output tnn_layer_pkg::score_t      scores [CLASS_CNT],
  output logic                       scores_done
);

  import tnn_layer_pkg::*;

  localparam int IDX_BITS = $clog2(HIDDEN_CNT + 1);

  logic [IDX_BITS-1:0] idx;                 // hidden neuron being fed
  logic                run;
  unit_sample_t        samples [CLASS_CNT];

  assign scores_done = (idx == IDX_BITS'(HIDDEN_CNT));
  assign run         = hidden_done && !scores_done;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx <= '0;
    end else if (run) begin
      idx <= idx + 1'b1;
    end
  end

  for (genvar c = 0; c < CLASS_CNT; c++) begin : g_class
    // weight times hidden bit as +/-1, zero where masked
    always_comb begin
      samples[c] = '0;
      for (int h = 0; h < HIDDEN_CNT; h++) begin
        if (idx == IDX_BITS'(h) && MASK[c*HIDDEN_CNT+h]) begin
          samples[c] = (hidden[h] ~^ SIGN[c*HIDDEN_CNT+h]) ? unit_sample_t'(1)
                                                           : unit_sample_t'(-1);
        end
      end
    end

    tnn_accumulator #(
      .SIZE     (HIDDEN_CNT),
      .sample_t (unit_sample_t),
      .ACC_BITS ($bits(score_t))
    ) u_acc (
      .clk    (clk),
      .rst    (rst),
      .sample (samples[c]),
      .halt   (!run),
      .sum    (scores[c]),
      .sign   ()
    );
  end

endmodule

// File: rtl/tnn_argmax.sv
`timescale 1ns/1ps

// ############################################################
// best class select, lowest index wins a tie
// ############################################################

module tnn_argmax #(
  parameter int CLASS_CNT = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  tnn_layer_pkg::score_t     scores [CLASS_CNT],
  input  logic                      scores_done,
  output tnn_layer_pkg::class_idx_t class_idx,
  output logic                      class_valid
);

  import tnn_layer_pkg::*;

  class_idx_t best_idx;
  score_t     best_score;

  // strictly greater keeps the first maximum
  always_comb begin
    best_idx   = '0;
    best_score = scores[0];
    for (int c = 1; c < CLASS_CNT; c++) begin
      if (scores[c] > best_score) begin
        best_score = scores[c];
        best_idx   = class_idx_t'(c);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      class_idx   <= '0;
      class_valid <= 1'b0;
    end else if (scores_done && !class_valid) begin  // capture once
      class_idx   <= best_idx;
      class_valid <= 1'b1;
    end
  end

endmodule

// File: rtl/tnn_classifier_top.sv
`timescale 1ns/1ps

`include "tnn_consts.svh"

// ############################################################
// two layer ternary classifier
// ############################################################

module tnn_classifier_top (
  input  logic                       clk,
  input  logic                       rst,
  input  tnn_feat_pkg::feat_vec_t    features,  // hold steady after reset
  output tnn_layer_pkg::tnn_result_t result
);

  import tnn_layer_pkg::*;

  hidden_vec_t hidden;
  logic        hidden_done;
  score_t      scores [`TNN_CLASS_CNT];
  logic        scores_done;
  class_idx_t  class_idx;
  logic        class_valid;

  tnn_first_layer #(
    .FEAT_CNT   (`TNN_FEAT_CNT),
    .FEAT_BITS  (`TNN_FEAT_BITS),
    .HIDDEN_CNT (`TNN_HIDDEN_CNT),
    .MASK       (`TNN_L1_MASK),
    .SIGN       (`TNN_L1_SIGN)
  ) u_first_layer (
    .clk         (clk),
    .rst         (rst),
    .features    (features),
    .hidden      (hidden),
    .hidden_done (hidden_done)
  );

  tnn_second_layer #(
    .HIDDEN_CNT (`TNN_HIDDEN_CNT),
    .CLASS_CNT  (`TNN_CLASS_CNT),
    .MASK       (`TNN_L2_MASK),
    .SIGN       (`TNN_L2_SIGN)
  ) u_second_layer (
    .clk         (clk),
    .rst         (rst),
    .hidden      (hidden),
    .hidden_done (hidden_done),
    .scores      (scores),
    .scores_done (scores_done)
  );

  tnn_argmax #(
    .CLASS_CNT (`TNN_CLASS_CNT)
  ) u_argmax (
    .clk         (clk),
    .rst         (rst),
    .scores      (scores),
    .scores_done (scores_done),
    .class_idx   (class_idx),
    .class_valid (class_valid)
  );

  assign result.valid     = class_valid;
  assign result.class_idx = class_idx;
  assign result.hidden    = hidden;  // final since edge 5

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

// ############################################################
// free running testbench clock
// ############################################################

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0  // full clock period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// File: dv/tb_tnn_classifier.sv
`timescale 1ns/1ps

`include "tnn_consts.svh"

module tb_tnn_classifier;

  import tnn_feat_pkg::*;
  import tnn_layer_pkg::*;

  localparam int  FEAT      = `TNN_FEAT_CNT;
  localparam int  HID       = `TNN_HIDDEN_CNT;
  localparam int  CLS       = `TNN_CLASS_CNT;
  localparam int  LATENCY   = 12;  // edges from reset release to valid
  localparam int  RST_CYC   = 16;
  localparam int  LCG_RUNS  = 20;
  localparam int  N_RUNS    = 1 + FEAT + LCG_RUNS;
  localparam int  CYC_LIMIT = N_RUNS * (RST_CYC + LATENCY + 10);
  localparam time DRV_DLY   = 1ns;  // drive after the rising edge

  localparam logic [HID*FEAT-1:0] L1_MASK = `TNN_L1_MASK;
  localparam logic [HID*FEAT-1:0] L1_SIGN = `TNN_L1_SIGN;
  localparam logic [CLS*HID-1:0]  L2_MASK = `TNN_L2_MASK;
  localparam logic [CLS*HID-1:0]  L2_SIGN = `TNN_L2_SIGN;

  logic        clk;
  logic        rst;
  feat_vec_t   features;
  tnn_result_t result;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'd44531;

  tb_clock_gen #(.PERIOD_NS(8.0)) u_clock_gen (.clk(clk));

  tnn_classifier_top u_tnn_classifier_top (
    .clk      (clk),
    .rst      (rst),
    .features (features),
    .result   (result)
  );

  // ############################################################
  // failure handling and checks
  // ############################################################

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_on_failure($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYC_LIMIT) begin
      stop_on_failure($sformatf("timeout: run still busy after %0d cycles", cycle_cnt));
    end
  end

  // ############################################################
  // reference model
  // ############################################################

  function automatic hidden_vec_t model_hidden(input feat_vec_t feat);
    hidden_vec_t hid;
    int          sum;
    for (int h = 0; h < HID; h++) begin
      sum = 0;
      for (int f = 0; f < FEAT; f++) begin
        if (L1_MASK[h*FEAT+f]) begin
          sum += L1_SIGN[h*FEAT+f] ? int'(feat[f]) : -int'(feat[f]);
        end
      end
      hid[h] = (sum >= 0);
    end
    return hid;
  endfunction

  // score is the ternary weight times the hidden bit as +/-1
  function automatic class_idx_t model_class(input hidden_vec_t hid);
    int         score;
    int         best_score;
    class_idx_t best;
    best       = '0;
    best_score = -100;
    for (int c = 0; c < CLS; c++) begin
      score = 0;
      for (int h = 0; h < HID; h++) begin
        if (L2_MASK[c*HID+h]) begin
          score += (hid[h] == L2_SIGN[c*HID+h]) ? 1 : -1;
        end
      end
      if (score > best_score) begin  // the first maximum wins
        best_score = score;
        best       = class_idx_t'(c);
      end
    end
    return best;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ############################################################
  // inference sequence
  // ############################################################

  task automatic run_inference(input feat_vec_t feat);
    int         edges;
    class_idx_t first_idx;
    @(posedge clk);
    #DRV_DLY;
    features = feat;
    rst      = 1'b1;
    for (int i = 0; i < RST_CYC; i++) begin
      @(posedge clk);
      #DRV_DLY;
      check_hex("result.valid during reset", 32'(result.valid), 0);
    end
    rst   = 1'b0;
    edges = 0;
    while (result.valid !== 1'b1 && edges <= LATENCY) begin
      @(posedge clk);
      #DRV_DLY;
      edges++;
    end
    check_hex("result.valid rise edge", 32'(edges), 32'(LATENCY));  // low through edge 11
    first_idx = result.class_idx;
    repeat (2) begin
      @(posedge clk);
      #DRV_DLY;
      check_hex("result.valid held", 32'(result.valid), 1);
      check_hex("result.class_idx held", 32'(result.class_idx), 32'(first_idx));
    end
  endtask

  task automatic check_result(input hidden_vec_t exp_hidden, input class_idx_t exp_class);
    check_hex("result.hidden", 32'(result.hidden), 32'(exp_hidden));
    check_hex("result.class_idx", 32'(result.class_idx), 32'(exp_class));
  endtask

  // ############################################################
  // directed tests
  // ############################################################

  task automatic test_all_zero();
    hidden_vec_t exp_hidden;
    exp_hidden = '1;  // every sum is exactly zero
    run_inference('0);
    check_result(exp_hidden, model_class(exp_hidden));
  endtask

  task automatic test_single_feature();
    feat_vec_t   feat;
    hidden_vec_t exp_hidden;
    for (int f = 0; f < FEAT; f++) begin
      feat    = '0;
      feat[f] = '1;
      for (int h = 0; h < HID; h++) begin
        exp_hidden[h] = L1_MASK[h*FEAT+f] ? L1_SIGN[h*FEAT+f] : 1'b1;
      end
      run_inference(feat);
      check_result(exp_hidden, model_class(exp_hidden));
    end
  endtask

  task automatic test_lcg_vectors();
    feat_vec_t   feat;
    hidden_vec_t exp_hidden;
    for (int n = 0; n < LCG_RUNS; n++) begin
      for (int f = 0; f < FEAT; f++) begin
        lcg_state = lcg_next(lcg_state);
        feat[f]   = lcg_state[27:24];  // upper bits since the low ones cycle fast
      end
      exp_hidden = model_hidden(feat);
      run_inference(feat);
      check_result(exp_hidden, model_class(exp_hidden));
    end
  endtask

  initial begin
    rst      = 1'b1;
    features = '0;
    test_all_zero();
    test_single_feature();
    test_lcg_vectors();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
rtl/tnn_feat_pkg.sv
rtl/tnn_layer_pkg.sv
rtl/tnn_accumulator.sv
rtl/tnn_first_layer.sv
rtl/tnn_second_layer.sv
rtl/tnn_argmax.sv
rtl/tnn_classifier_top.sv
dv/tb_clock_gen.sv
dv/tb_tnn_classifier.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_tnn_classifier
RTL_TOP    ?= tnn_classifier_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

# lint the design alone, then together with the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) +incdir+rtl \
		rtl/tnn_feat_pkg.sv rtl/tnn_layer_pkg.sv rtl/tnn_accumulator.sv \
		rtl/tnn_first_layer.sv rtl/tnn_second_layer.sv rtl/tnn_argmax.sv \
		rtl/tnn_classifier_top.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
